// File: build.f
kbd_pkg.sv
ps2_rx.sv
scan_fifo.sv
key_decoder.sv
kbd_top.sv
tb_kbd_top.sv

// File: kbd_pkg.sv
`default_nettype none

package kbd_pkg;

    localparam int FRAME_BITS = 11;              // Start, 8 data, parity, stop
    localparam int BIT_CNT_W  = 4;
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;
    localparam int COUNT_W    = 8;

    localparam logic [7:0] CODE_EXT   = 8'hE0;   // Extended key prefix
    localparam logic [7:0] CODE_BREAK = 8'hF0;   // Release prefix

    // Scan code set 2 to ASCII, letters and digits only
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
        logic [7:0] ascii;
        case (code)
            8'h1C: ascii = "A";
            8'h32: ascii = "B";
            8'h21: ascii = "C";
            8'h23: ascii = "D";
            8'h24: ascii = "E";
            8'h2B: ascii = "F";
            8'h34: ascii = "G";
            8'h33: ascii = "H";
            8'h43: ascii = "I";
            8'h3B: ascii = "J";
            8'h42: ascii = "K";
            8'h4B: ascii = "L";
            8'h3A: ascii = "M";
            8'h31: ascii = "N";
            8'h44: ascii = "O";
            8'h4D: ascii = "P";
            8'h15: ascii = "Q";
            8'h2D: ascii = "R";
            8'h1B: ascii = "S";
            8'h2C: ascii = "T";
            8'h3C: ascii = "U";
            8'h2A: ascii = "V";
            8'h1D: ascii = "W";
            8'h22: ascii = "X";
            8'h35: ascii = "Y";
            8'h1A: ascii = "Z";
            8'h45: ascii = "0";
            8'h16: ascii = "1";
            8'h1E: ascii = "2";
            8'h26: ascii = "3";
            8'h25: ascii = "4";
            8'h2E: ascii = "5";
            8'h36: ascii = "6";
            8'h3D: ascii = "7";
            8'h3E: ascii = "8";
            8'h46: ascii = "9";
            default: ascii = 8'h00;              // Any other key
        endcase
        return ascii;
    endfunction

endpackage

`default_nettype wire

// File: kbd_top.sv
`default_nettype none

module kbd_top import kbd_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire                ps2_clk,
    input  wire                ps2_data,
    input  wire                key_ready,
    output logic               key_valid,
    output logic [7:0]         key_code,
    output logic [7:0]         key_ascii,
    output logic               key_break,
    output logic               key_ext,
    output logic [COUNT_W-1:0] release_count,
    output logic               frame_error,
    output logic               overflow
);

    logic [7:0] rx_byte;
    logic       rx_valid;               // Single-cycle push, no stall
    logic [7:0] fifo_byte;
    logic       fifo_valid;
    logic       fifo_ready;

    ps2_rx u_ps2_rx (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .frame_error (frame_error)
    );

    scan_fifo u_scan_fifo (
        .clk        (clk),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .fifo_byte  (fifo_byte),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready),
        .overflow   (overflow)
    );

    key_decoder u_key_decoder (
        .clk           (clk),
        .reset         (reset),
        .fifo_byte     (fifo_byte),
        .fifo_valid    (fifo_valid),
        .fifo_ready    (fifo_ready),
        .key_ready     (key_ready),
        .key_valid     (key_valid),
        .key_code      (key_code),
        .key_ascii     (key_ascii),
        .key_break     (key_break),
        .key_ext       (key_ext),
        .release_count (release_count)
    );

endmodule

`default_nettype wire

// File: key_decoder.sv
`default_nettype none

module key_decoder import kbd_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire  [7:0]         fifo_byte,
    input  wire                fifo_valid,
    output logic               fifo_ready,
    input  wire                key_ready,
    output logic               key_valid,
    output logic [7:0]         key_code,
    output logic [7:0]         key_ascii,
    output logic               key_break,
    output logic               key_ext,
    output logic [COUNT_W-1:0] release_count
);

    logic pend_ext;                     // E0 seen for the coming key
    logic pend_break;                   // F0 seen for the coming key
    logic take;
    logic is_ext;
    logic is_break;
    logic is_final;

    // One event buffer, so bytes are only taken while it is empty
    assign fifo_ready = ~key_valid;
    assign take       = fifo_valid & fifo_ready;
    assign is_ext     = (fifo_byte == CODE_EXT);
    assign is_break   = (fifo_byte == CODE_BREAK);
    assign is_final   = take & ~is_ext & ~is_break;

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_ext      <= 1'b0;
            pend_break    <= 1'b0;
            key_valid     <= 1'b0;
            release_count <= '0;
        end else begin
            if (key_valid && key_ready) begin
                key_valid <= 1'b0;
            end
            if (take && is_ext) begin
                pend_ext <= 1'b1;
            end
            if (take && is_break) begin
                pend_break <= 1'b1;
            end
            if (is_final) begin
                key_valid  <= 1'b1;
                pend_ext   <= 1'b0;                 // Prefixes apply to one key
                pend_break <= 1'b0;
                if (pend_break) begin
                    release_count <= release_count + 1'b1;
                end
            end
        end
    end

    // Event fields, loaded only when a final byte is taken
    always_ff @(posedge clk) begin
        if (is_final) begin
            key_code  <= fifo_byte;
            key_ascii <= scan_to_ascii(fifo_byte);
            key_break <= pend_break;
            key_ext   <= pend_ext;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        key_valid && !key_ready |=> key_valid
            && $stable({key_code, key_ascii, key_break, key_ext}))
        else $error("key_decoder: event changed while stalled");

endmodule

`default_nettype wire

// File: ps2_rx.sv
`default_nettype none

module ps2_rx import kbd_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        ps2_clk,
    input  wire        ps2_data,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_error
);

    logic [2:0]            clk_sync;    // Two sync stages plus edge history
    logic [1:0]            data_sync;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [FRAME_BITS-2:0] shift;       // Start, data and parity bits
    logic                  fall;
    logic                  last_bit;
    logic                  frame_ok;

    assign fall     = clk_sync[2] & ~clk_sync[1];
    assign last_bit = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

    // Stop bit is still on the synchronized data line
    assign frame_ok = ~shift[0]                     // Start bit low
                    & data_sync[1]                  // Stop bit high
                    & (^shift[FRAME_BITS-2:1]);     // Odd parity

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= '1;                        // Idle lines are high
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt     <= '0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (fall) begin
                if (last_bit) begin
                    bit_cnt <= '0;                  // Restart on every frame
                    if (frame_ok) begin
                        rx_valid <= 1'b1;
                    end else begin
                        frame_error <= 1'b1;        // Sticky until reset
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall) begin
            if (last_bit) begin
                rx_byte <= shift[FRAME_BITS-3:1];
            end else begin
                shift[bit_cnt] <= data_sync[1];
            end
        end
    end

    // The keyboard clock is far slower than clk, so pushes never merge
    assert property (@(posedge clk) disable iff (reset) rx_valid |=> !rx_valid)
        else $error("ps2_rx: rx_valid high on consecutive cycles");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the PS/2 keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_kbd_top -f build.f -o tb_kbd_top > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_kbd_top > sim.log 2>&1
cat sim.log

grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: scan_fifo.sv
`default_nettype none

module scan_fifo import kbd_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire  [7:0] rx_byte,
    input  wire        rx_valid,
    output logic [7:0] fifo_byte,
    output logic       fifo_valid,
    input  wire        fifo_ready,
    output logic       overflow
);

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;          // Occupancy, 0 to FIFO_DEPTH
    logic               full;
    logic               push;
    logic               pop;

    assign full       = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign pop        = fifo_valid & fifo_ready;
    assign push       = rx_valid & (~full | pop);   // Full but draining is fine
    assign fifo_valid = (count != '0);
    assign fifo_byte  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;            // Wraps at FIFO_DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (rx_valid && !push) begin
                overflow <= 1'b1;                   // Byte dropped
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rx_byte;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        count <= (FIFO_AW + 1)'(FIFO_DEPTH))
        else $error("scan_fifo: occupancy above depth");

    assert property (@(posedge clk) disable iff (reset)
        fifo_valid && !fifo_ready |=> fifo_valid && $stable(fifo_byte))
        else $error("scan_fifo: head byte changed while stalled");

endmodule

`default_nettype wire

// File: tb_kbd_top.sv
`default_nettype none

module tb_kbd_top import kbd_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_CYCLES = 10;            // Keyboard clock half period
    localparam int GAP_CYCLES  = 10;
    localparam int MAX_CYCLES  = 8000;          // 24 frames of about 230 cycles plus drain

    logic               clk;
    logic               reset;
    logic               ps2_clk;
    logic               ps2_data;
    logic               key_ready;
    logic               key_valid;
    logic [7:0]         key_code;
    logic [7:0]         key_ascii;
    logic               key_break;
    logic               key_ext;
    logic [COUNT_W-1:0] release_count;
    logic               frame_error;
    logic               overflow;

    integer             seed = 32'h46b4db30;
    int                 errors = 0;
    int                 missing = 0;
    int                 cycles;
    logic               hold_ready = 1'b0;
    logic               accept;

    // Expected events, written in send order
    logic [7:0]         exp_code  [32];
    logic [7:0]         exp_ascii [32];
    logic               exp_break [32];
    logic               exp_ext   [32];
    logic [COUNT_W-1:0] exp_rel   [32];
    logic [4:0]         exp_wr = '0;
    logic [4:0]         exp_rd = '0;
    logic [COUNT_W-1:0] rel_total = '0;
    logic [7:0]         head_code;
    logic [7:0]         head_ascii;
    logic               head_break;
    logic               head_ext;
    logic [COUNT_W-1:0] head_rel;

    kbd_top u_kbd_top (
        .clk           (clk),
        .reset         (reset),
        .ps2_clk       (ps2_clk),
        .ps2_data      (ps2_data),
        .key_ready     (key_ready),
        .key_valid     (key_valid),
        .key_code      (key_code),
        .key_ascii     (key_ascii),
        .key_break     (key_break),
        .key_ext       (key_ext),
        .release_count (release_count),
        .frame_error   (frame_error),
        .overflow      (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign accept = key_valid && key_ready;

    always @(posedge clk) begin
        if (!reset && accept) begin
            exp_rd <= exp_rd + 1'b1;
        end
    end

    // Head moves between edges, so it is steady when an event is taken
    always @(negedge clk) begin
        head_code  <= exp_code[exp_rd];
        head_ascii <= exp_ascii[exp_rd];
        head_break <= exp_break[exp_rd];
        head_ext   <= exp_ext[exp_rd];
        head_rel   <= exp_rel[exp_rd];
    end

    assert property (@(posedge clk) disable iff (reset) accept |-> exp_rd != exp_wr)
        else begin
            errors++;
            $display("%0t: the DUT gave a key event that was never sent", $time);
        end
    assert property (@(posedge clk) disable iff (reset) accept |-> key_code == head_code)
        else begin
            errors++;
            $display("[FAIL] %0t key_code got %h exp %h", $time, key_code, head_code);
        end
    assert property (@(posedge clk) disable iff (reset) accept |-> key_ascii == head_ascii)
        else begin
            errors++;
            $display("[FAIL] %0t key_ascii got %h exp %h", $time, key_ascii, head_ascii);
        end
    assert property (@(posedge clk) disable iff (reset) accept |-> key_break == head_break)
        else begin
            errors++;
            $display("[FAIL] %0t key_break got %b exp %b", $time, key_break, head_break);
        end
    assert property (@(posedge clk) disable iff (reset) accept |-> key_ext == head_ext)
        else begin
            errors++;
            $display("[FAIL] %0t key_ext got %b exp %b", $time, key_ext, head_ext);
        end
    assert property (@(posedge clk) disable iff (reset) accept |-> release_count == head_rel)
        else begin
            errors++;
            $display("[FAIL] %0t release_count got %0d exp %0d", $time, release_count, head_rel);
        end

    task automatic check_flag(input string name, input logic got, input logic exp);
        assert (got === exp)
            else begin
                errors++;
                $display("[FAIL] %0t %s got %b exp %b", $time, name, got, exp);
            end
    endtask

    // Start bit, data LSB first, odd parity, stop bit
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [FRAME_BITS-1:0] bits;
        bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        repeat (FRAME_BITS) begin
            ps2_data <= bits[0];
            bits = bits >> 1;
            repeat (HALF_CYCLES) @(posedge clk);
            ps2_clk <= 1'b0;                    // Receiver samples here
            repeat (HALF_CYCLES) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        ps2_data <= 1'b1;
        repeat (GAP_CYCLES) @(posedge clk);
    endtask

    task automatic expect_key(input logic [7:0] code, input logic brk, input logic ext);
        exp_code[exp_wr]  = code;
        exp_ascii[exp_wr] = scan_to_ascii(code);
        exp_break[exp_wr] = brk;
        exp_ext[exp_wr]   = ext;
        if (brk) begin
            rel_total = rel_total + 1'b1;
        end
        exp_rel[exp_wr] = rel_total;
        exp_wr = exp_wr + 1'b1;
    endtask

    task automatic send_key(input logic [7:0] code, input logic brk, input logic ext);
        if (ext) begin
            send_frame(CODE_EXT, 1'b0);
        end
        if (brk) begin
            send_frame(CODE_BREAK, 1'b0);
        end
        expect_key(code, brk, ext);             // Queued before the event can appear
        send_frame(code, 1'b0);
    endtask

    function automatic logic [7:0] random_key();
        logic [7:0] code;
        code = 8'($random(seed));
        while (scan_to_ascii(code) == 8'h00) begin
            code = 8'($random(seed));
        end
        return code;
    endfunction

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_rd != exp_wr && waited < 1000) begin
            @(posedge clk);
            waited++;
        end
    endtask

    // Random draw on the falling edge, applied on the rising one
    initial begin
        logic [31:0] gap;
        key_ready <= 1'b0;
        forever begin
            @(negedge clk);
            gap = $random(seed);
            @(posedge clk);
            if (hold_ready) begin
                key_ready <= 1'b0;
            end else begin
                key_ready <= (gap[1:0] != 2'b00);   // Idle about one cycle in four
            end
        end
    end

    initial begin
        reset    <= 1'b1;
        ps2_clk  <= 1'b1;
        ps2_data <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_flag("key_valid", key_valid, 1'b0);
        check_flag("frame_error", frame_error, 1'b0);
        check_flag("overflow", overflow, 1'b0);
        assert (release_count === '0)
            else begin
                errors++;
                $display("[FAIL] %0t release_count got %0d exp 0", $time, release_count);
            end

        repeat (3) send_key(random_key(), 1'b0, 1'b0);
        repeat (2) send_key(random_key(), 1'b1, 1'b0);
        send_key(8'h75, 1'b0, 1'b1);            // Up arrow, outside the table
        send_key(8'h75, 1'b1, 1'b1);
        wait_drain();

        send_frame(random_key(), 1'b1);         // Wrong parity, dropped
        check_flag("frame_error", frame_error, 1'b1);
        send_key(random_key(), 1'b0, 1'b0);
        wait_drain();

        // One code held in the decoder, the rest fill the FIFO
        hold_ready = 1'b1;
        repeat (FIFO_DEPTH + 1) send_key(random_key(), 1'b0, 1'b0);
        check_flag("overflow", overflow, 1'b0);
        send_frame(random_key(), 1'b0);
        check_flag("overflow", overflow, 1'b1);
        hold_ready = 1'b0;
        wait_drain();

        missing = int'(exp_wr - exp_rd);
        if (missing != 0) begin
            $display("%0d expected key events never came out of the DUT", missing);
        end
        $display("Summary: %0d check errors, %0d missing events", errors, missing);
        if (errors == 0 && missing == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
